//--- uart_core.f
hdl/uart_pkg.sv
hdl/sync_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_core.sv
verification/uart_core_checker.sv
verification/uart_core_tb.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := uart_core_tb
FILELIST   := uart_core.f
BUILD_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/uart_core_tb.sv
/*
 * Directed tests for uart_core. Inputs change on the falling clock edge.
 * rx_serial comes from the testbench, or from tx_serial in loopback.
 */
`timescale 1ns/100ps

module uart_core_tb;
    logic               clk;
    logic               nRst;
    logic               tx_write;
    logic [7:0]         tx_data;
    logic               tx_full;
    logic               tx_serial;
    logic               rx_serial;
    logic               rx_drive;
    logic               loopback;
    logic               rx_read;
    logic               rx_empty;
    logic [7:0]         rx_data;
    logic               rx_parity_error;
    logic               rx_framing_error;
    int                 cycle_count = 0;
    uart_pkg::tx_byte_t sent_bytes [6];

    assign rx_serial = loopback ? tx_serial : rx_drive;

    uart_core dut_i (
        .clk(clk), .nRst(nRst), .tx_write(tx_write), .tx_data(tx_data), .tx_full(tx_full),
        .tx_serial(tx_serial), .rx_serial(rx_serial), .rx_read(rx_read),
        .rx_empty(rx_empty), .rx_data(rx_data), .rx_parity_error(rx_parity_error),
        .rx_framing_error(rx_framing_error)
    );

    always #5 clk = ~clk;

    // watchdog at 40 frame lengths.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 40 * 11 * uart_pkg::CLKS_PER_BAUD) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the watchdog");
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input uart_pkg::tx_byte_t exp,
                              input uart_pkg::tx_byte_t act);
        if (act !== exp) begin
            report_failure($sformatf("error at %0t: %s expected %h, got %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_frame(input string name, input uart_pkg::rx_frame_t exp,
                               input uart_pkg::rx_frame_t act);
        if (act !== exp) begin
            report_failure($sformatf("error at %0t: %s expected %h/%b/%b, got %h/%b/%b",
                $time, name, exp.data, exp.parity_error, exp.framing_error,
                act.data, act.parity_error, act.framing_error));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("error at %0t: %s expected %b, got %b",
                $time, name, exp, act));
        end
    endtask

    // parity as the count of ones modulo two.
    function automatic logic even_parity(input uart_pkg::tx_byte_t b);
        return ($countones(b) % 2) == 1;
    endfunction

    function automatic uart_pkg::rx_frame_t make_frame(input logic [7:0] d, input logic pe,
                                                       input logic fe);
        uart_pkg::rx_frame_t f;
        f.data          = d;
        f.parity_error  = pe;
        f.framing_error = fe;
        return f;
    endfunction

    task automatic drive_rx_frame(input uart_pkg::tx_byte_t d, input logic bad_parity,
                                  input logic stop_bit);
        logic [10:0] bits;
        bits = {stop_bit, even_parity(d) ^ bad_parity, d, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge clk);
            rx_drive = bits[i];
            repeat (uart_pkg::CLKS_PER_BAUD - 1) @(negedge clk);
        end
        @(negedge clk);
        rx_drive = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    // sample each bit near its middle.
    task automatic capture_tx_frame(output uart_pkg::tx_byte_t d, output logic parity_bit);
        logic [10:0] bits;
        while (tx_serial !== 1'b0) @(negedge clk);
        repeat (uart_pkg::CLKS_PER_BAUD / 2 - 1) @(negedge clk);
        bits[0] = tx_serial;
        for (int i = 1; i < 11; i++) begin
            repeat (uart_pkg::CLKS_PER_BAUD) @(negedge clk);
            bits[i] = tx_serial;
        end
        d          = bits[8:1];
        parity_bit = bits[9];
        check_bit("tx_serial start bit", 1'b0, bits[0]);
        check_bit("tx_serial stop bit", 1'b1, bits[10]);
    endtask

    task automatic write_tx_burst(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            tx_write = 1'b1;
            tx_data  = sent_bytes[i];
        end
        @(negedge clk);
        tx_write = 1'b0;
    endtask

    task automatic expect_rx_frame(input uart_pkg::rx_frame_t exp);
        while (rx_empty) @(negedge clk);
        check_frame("rx frame", exp, make_frame(rx_data, rx_parity_error, rx_framing_error));
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            sent_bytes[i] = uart_pkg::tx_byte_t'($urandom());
        end
    endtask

    task automatic test_reset_state();
        check_bit("tx_serial", 1'b1, tx_serial);
        check_bit("tx_full", 1'b0, tx_full);
        check_bit("rx_empty", 1'b1, rx_empty);
    endtask

    // writes run alongside the capture so the first start bit is not missed.
    task automatic test_transmit(input int n_write, input int n_frames, input logic full_after);
        uart_pkg::tx_byte_t got;
        logic               got_parity;
        fill_random(n_write);
        fork
            begin
                write_tx_burst(n_write);
                check_bit("tx_full", full_after, tx_full);
            end
            for (int i = 0; i < n_frames; i++) begin
                capture_tx_frame(got, got_parity);
                check_byte("tx_serial data", sent_bytes[i], got);
                check_bit("tx_serial parity bit", even_parity(sent_bytes[i]), got_parity);
            end
        join
        // nothing more may leave the serializer.
        repeat (11 * uart_pkg::CLKS_PER_BAUD) begin
            @(negedge clk);
            check_bit("tx_serial idle", 1'b1, tx_serial);
        end
    endtask

    task automatic test_rx_good();
        fill_random(4);
        for (int i = 0; i < 4; i++) begin
            drive_rx_frame(sent_bytes[i], 1'b0, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            expect_rx_frame(make_frame(sent_bytes[i], 1'b0, 1'b0));
        end
        check_bit("rx_empty", 1'b1, rx_empty);
    endtask

    task automatic test_rx_errors();
        fill_random(2);
        drive_rx_frame(sent_bytes[0], 1'b1, 1'b1);
        expect_rx_frame(make_frame(sent_bytes[0], 1'b1, 1'b0));
        drive_rx_frame(sent_bytes[1], 1'b0, 1'b0);
        expect_rx_frame(make_frame(sent_bytes[1], 1'b0, 1'b1));
        // false start that returns high well before the midpoint.
        @(negedge clk);
        rx_drive = 1'b0;
        repeat (uart_pkg::CLKS_PER_BAUD / 4) @(negedge clk);
        rx_drive = 1'b1;
        repeat (11 * uart_pkg::CLKS_PER_BAUD) @(negedge clk);
        check_bit("rx_empty", 1'b1, rx_empty);
    endtask

    task automatic test_loopback();
        fill_random(3);
        @(negedge clk);
        loopback = 1'b1;
        write_tx_burst(3);
        for (int i = 0; i < 3; i++) begin
            expect_rx_frame(make_frame(sent_bytes[i], 1'b0, 1'b0));
        end
        check_bit("rx_empty", 1'b1, rx_empty);
        loopback = 1'b0;
    endtask

    initial begin
        void'($urandom(89058));
        clk      = 1'b0;
        nRst     = 1'b0;
        tx_write = 1'b0;
        tx_data  = '0;
        rx_drive = 1'b1;
        rx_read  = 1'b0;
        loopback = 1'b0;
        repeat (5) @(negedge clk);
        nRst = 1'b1;
        test_reset_state();
        test_transmit(3, 3, 1'b0);
        test_rx_good();
        test_rx_errors();
        // the serializer holds one byte and the buffer four, so the sixth is dropped.
        test_transmit(6, 5, 1'b1);
        test_loopback();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- verification/uart_core_checker.sv
/*
 * Assertions on uart_core internals, attached with bind.
 * Assumes the serializer encodes its idle state as zero.
 */
`timescale 1ns/100ps

module uart_core_checker (
    input logic                                        clk,
    input logic                                        nRst,
    input logic [2:0]                                  tx_state,
    input logic                                        tx_serial,
    input logic                                        frame_valid,
    input logic [$clog2(uart_pkg::FIFO_DEPTH + 1)-1:0] tx_count,
    input logic [$clog2(uart_pkg::FIFO_DEPTH + 1)-1:0] rx_count
);
    // idle serializer holds the line high.
    tx_idle_high: assert property (@(posedge clk) disable iff (!nRst)
        (tx_state == 3'd0) |-> tx_serial)
        else $error("tx_serial low while the serializer is idle");

    frame_valid_pulse: assert property (@(posedge clk) disable iff (!nRst)
        frame_valid |=> !frame_valid)
        else $error("frame_valid high for more than one cycle");

    fifo_bounded: assert property (@(posedge clk) disable iff (!nRst)
        (int'(tx_count) <= uart_pkg::FIFO_DEPTH) && (int'(rx_count) <= uart_pkg::FIFO_DEPTH))
        else $error("buffer occupancy above FIFO_DEPTH");

endmodule

bind uart_core uart_core_checker checker_i (
    .clk(clk), .nRst(nRst), .tx_state(tx_i.state), .tx_serial(tx_serial),
    .frame_valid(rx_frame_valid), .tx_count(tx_fifo_i.count), .rx_count(rx_fifo_i.count)
);

//--- hdl/uart_core.sv
/*
 * UART peripheral: transmit buffer and serializer, receiver and receive buffer.
 * No back-pressure. Writes to a full transmit buffer and frames arriving
 * at a full receive buffer are dropped.
 */
`timescale 1ns/100ps

module uart_core (
    input  logic       clk,
    input  logic       nRst,
    input  logic       tx_write,
    input  logic [7:0] tx_data,
    output logic       tx_full,
    output logic       tx_serial,
    input  logic       rx_serial,
    input  logic       rx_read,
    output logic       rx_empty,
    output logic [7:0] rx_data,
    output logic       rx_parity_error,
    output logic       rx_framing_error
);
    uart_pkg::tx_byte_t  tx_head;
    logic                tx_not_empty;
    logic                tx_pop;
    uart_pkg::rx_frame_t rx_frame;
    logic                rx_frame_valid;
    uart_pkg::rx_frame_t rx_head;
    logic                rx_not_empty;

    sync_fifo #(.payload_t(uart_pkg::tx_byte_t), .DEPTH(uart_pkg::FIFO_DEPTH)) tx_fifo_i (
        .clk(clk), .nRst(nRst), .push(tx_write), .wdata(tx_data), .pop(tx_pop),
        .rdata(tx_head), .not_empty(tx_not_empty), .full(tx_full)
    );

    uart_tx tx_i (
        .clk(clk), .nRst(nRst), .byte_ready(tx_not_empty), .tx_byte(tx_head),
        .pop(tx_pop), .tx_serial(tx_serial)
    );

    uart_rx rx_i (
        .clk(clk), .nRst(nRst), .rx_serial(rx_serial),
        .frame_valid(rx_frame_valid), .frame(rx_frame)
    );

    // the buffer itself drops a frame that arrives while it is full.
    sync_fifo #(.payload_t(uart_pkg::rx_frame_t), .DEPTH(uart_pkg::FIFO_DEPTH)) rx_fifo_i (
        .clk(clk), .nRst(nRst), .push(rx_frame_valid), .wdata(rx_frame), .pop(rx_read),
        .rdata(rx_head), .not_empty(rx_not_empty), .full()
    );

    assign rx_empty         = !rx_not_empty;
    assign rx_data          = rx_head.data;
    assign rx_parity_error  = rx_head.parity_error;
    assign rx_framing_error = rx_head.framing_error;

endmodule

//--- hdl/uart_rx.sv
/*
 * 8E1 receiver with mid-bit sampling after a two-flop synchronizer.
 * A start bit that is high at its midpoint is treated as noise.
 * Every completed frame is emitted with its parity and framing flags.
 * After a frame the line must return high before a new start bit is accepted.
 */
`timescale 1ns/100ps

module uart_rx (
    input  logic                clk,
    input  logic                nRst,
    input  logic                rx_serial,
    output logic                frame_valid,
    output uart_pkg::rx_frame_t frame
);
    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP,
        CLEAN
    } rx_state_t;

    typedef logic [uart_pkg::BAUD_CNT_W-1:0] baud_cnt_t;

    logic       rx_meta;
    logic       rx_sync;
    rx_state_t  state;
    rx_state_t  next_state;
    baud_cnt_t  baud_cnt;
    baud_cnt_t  next_baud_cnt;
    logic [2:0] bit_idx;
    logic [2:0] next_bit_idx;
    logic       ones;
    logic       next_ones;
    logic       parity_error;
    logic       next_parity_error;
    logic [7:0] data_sr;
    logic       baud_half;
    logic       baud_end;

    assign baud_half = (baud_cnt == baud_cnt_t'((uart_pkg::CLKS_PER_BAUD - 1) / 2));
    assign baud_end  = (baud_cnt == baud_cnt_t'(uart_pkg::CLKS_PER_BAUD - 1));

    // line idles high.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= IDLE;
            baud_cnt     <= '0;
            bit_idx      <= '0;
            ones         <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            state        <= next_state;
            baud_cnt     <= next_baud_cnt;
            bit_idx      <= next_bit_idx;
            ones         <= next_ones;
            parity_error <= next_parity_error;
        end
    end

    // lsb arrives first.
    always_ff @(posedge clk) begin
        if ((state == DATA) && baud_end) begin
            data_sr <= {rx_sync, data_sr[7:1]};
        end
    end

    always_comb begin
        next_state        = state;
        next_baud_cnt     = baud_cnt + 1'b1;
        next_bit_idx      = bit_idx;
        next_ones         = ones;
        next_parity_error = parity_error;
        frame_valid       = 1'b0;
        case (state)
            IDLE: begin
                next_baud_cnt = '0;
                if (!rx_sync) begin
                    next_state        = START;
                    next_bit_idx      = '0;
                    next_ones         = 1'b0;
                    next_parity_error = 1'b0;
                end
            end
            START: begin
                // recheck the start bit at its middle.
                if (baud_half) begin
                    next_baud_cnt = '0;
                    next_state    = rx_sync ? IDLE : DATA;
                end
            end
            DATA: begin
                if (baud_end) begin
                    next_baud_cnt = '0;
                    next_ones     = ones ^ rx_sync;
                    next_bit_idx  = bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        next_state = PARITY;
                    end
                end
            end
            PARITY: begin
                // parity bit must equal the ones count modulo two.
                if (baud_end) begin
                    next_baud_cnt     = '0;
                    next_parity_error = (rx_sync != ones);
                    next_state        = STOP;
                end
            end
            STOP: begin
                if (baud_end) begin
                    next_baud_cnt = '0;
                    frame_valid   = 1'b1;
                    next_state    = CLEAN;
                end
            end
            CLEAN: begin
                next_baud_cnt = '0;
                if (rx_sync) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_baud_cnt = '0;
                next_state    = IDLE;
            end
        endcase
    end

    // framing flag is the stop bit sampled in the pulse cycle.
    assign frame = '{data: data_sr, parity_error: parity_error, framing_error: !rx_sync};

endmodule

//--- hdl/uart_tx.sv
/*
 * 8E1 serializer: start, eight data bits LSB first, even parity, stop.
 * Pops the next byte on the last stop cycle, so frames can run back to back.
 */
`timescale 1ns/100ps

module uart_tx (
    input  logic               clk,
    input  logic               nRst,
    input  logic               byte_ready,
    input  uart_pkg::tx_byte_t tx_byte,
    output logic               pop,
    output logic               tx_serial
);
    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } tx_state_t;

    typedef logic [uart_pkg::BAUD_CNT_W-1:0] baud_cnt_t;

    tx_state_t          state;
    baud_cnt_t          baud_cnt;
    logic [2:0]         bit_idx;
    uart_pkg::tx_byte_t shift_reg;
    logic               parity;
    logic               baud_end;

    assign baud_end = (baud_cnt == baud_cnt_t'(uart_pkg::CLKS_PER_BAUD - 1));

    // take a byte when idle or when the stop bit is just ending.
    assign pop = byte_ready && ((state == IDLE) || ((state == STOP) && baud_end));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            parity   <= 1'b0;
        end else if (pop) begin
            state    <= START;
            baud_cnt <= '0;
            bit_idx  <= '0;
            parity   <= 1'b0;
        end else if (state != IDLE) begin
            if (baud_end) begin
                baud_cnt <= '0;
                case (state)
                    START: state <= DATA;
                    DATA: begin
                        // running count of ones, modulo two.
                        parity  <= parity ^ shift_reg[0];
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY:  state <= STOP;
                    default: state <= IDLE;
                endcase
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= tx_byte;
        end else if ((state == DATA) && baud_end) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    always_comb begin
        case (state)
            START:   tx_serial = 1'b0;
            DATA:    tx_serial = shift_reg[0];
            PARITY:  tx_serial = parity;
            default: tx_serial = 1'b1;
        endcase
    end

endmodule

//--- hdl/sync_fifo.sv
/*
 * Show-ahead circular buffer. rdata is only meaningful while not_empty is high.
 * Push on full is dropped unless paired with a pop. Pop on empty is ignored.
 */
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     nRst,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     not_empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop  = pop && not_empty;
    // a pop frees the slot for a push in the same cycle.
    assign do_push = push && (!full || do_pop);

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign rdata     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/uart_pkg.sv
/*
 * Fixed 8E1 format with no run-time configuration.
 * The bit period is kept short for simulation. Raise CLKS_PER_BAUD for real baud rates.
 */
package uart_pkg;

    // clocks per bit period.
    localparam int CLKS_PER_BAUD = 16;
    localparam int BAUD_CNT_W    = $clog2(CLKS_PER_BAUD);

    // entries in each buffer.
    localparam int FIFO_DEPTH = 4;

    typedef logic [7:0] tx_byte_t;

    // received byte with its error flags.
    typedef struct packed {
        logic [7:0] data;
        logic       parity_error;
        logic       framing_error;
    } rx_frame_t;

endpackage
